// ==== ddr_rwtest_params.svh ====
`ifndef DDR_RWTEST_PARAMS_SVH
`define DDR_RWTEST_PARAMS_SVH

// Controller port widths.
`define DDR_ADDR_W 30
`define DDR_DATA_W 32
`define DDR_CMD_W 3

// Test control widths.
`define DDR_ITER_W 16
`define DDR_ERR_W 8
`define DDR_INCR_W 8
`define DDR_ERR_MAX 255

// Statistics widths.
`define DDR_CNT_W 32
`define DDR_STALL_W 16

// Feedback taps of the pattern LFSR.
`define DDR_LFSR_TAP_A 31
`define DDR_LFSR_TAP_B 21
`define DDR_LFSR_TAP_C 1
`define DDR_LFSR_TAP_D 0

// Native interface command codes.
`define DDR_CMD_WRITE 3'b000
`define DDR_CMD_READ 3'b001

`endif

// ==== ddr_rwtest_pkg.sv ====
`default_nettype none

`include "ddr_rwtest_params.svh"

package ddr_rwtest_pkg;

   typedef logic [`DDR_ADDR_W-1:0]  ddr_addr_t;
   typedef logic [`DDR_DATA_W-1:0]  ddr_data_t;   // Also the LFSR state.
   typedef logic [`DDR_ITER_W-1:0]  iter_t;
   typedef logic [`DDR_ERR_W-1:0]   err_cnt_t;
   typedef logic [`DDR_INCR_W-1:0]  incr_t;
   typedef logic [`DDR_CNT_W-1:0]   perf_cnt_t;
   typedef logic [`DDR_STALL_W-1:0] stall_t;

   typedef enum logic [`DDR_CMD_W-1:0] {
      cmd_write = `DDR_CMD_WRITE,
      cmd_read  = `DDR_CMD_READ
   } app_cmd_e;

   typedef enum logic [3:0] {
      st_write0,
      st_write1,
      st_write2,
      st_read0,
      st_read1,
      st_read2,
      st_wait_reads_done,
      st_idle,
      st_load_lfsr
   } seq_state_e;

   typedef struct packed {
      ddr_addr_t addr;
      app_cmd_e  cmd;
      logic      en;
      ddr_data_t wdf_data;
      logic      wdf_wren;
      logic      wdf_end;
   } app_req_t;

   typedef struct packed {
      ddr_data_t rd_data;
      logic      rd_data_end;
      logic      rd_data_valid;
      logic      rdy;
      logic      wdf_rdy;
   } app_rsp_t;

   typedef struct packed {
      incr_t     incr;
      ddr_addr_t stop;
   } test_cfg_t;

   typedef struct packed {
      logic      valid;
      ddr_data_t expected;
      ddr_addr_t addr;
   } check_beat_t;

   typedef struct packed {
      logic      pass;
      logic      fail;
      iter_t     iteration;
      err_cnt_t  errors;
      ddr_addr_t error_addr;
   } test_status_t;

   typedef struct packed {
      perf_cnt_t read_read;
      perf_cnt_t read_idle;
      perf_cnt_t write_write;
      perf_cnt_t write_idle;
      stall_t    max_read_stall;
      stall_t    max_write_stall;
   } perf_stats_t;

endpackage

`default_nettype wire

// ==== ddr_rwtest_sequencer.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "ddr_rwtest_params.svh"

module ddr_rwtest_sequencer import ddr_rwtest_pkg::*; (
   input  wire logic  clk,
   input  wire logic  reset,
   input  wire logic  active_async,
   input  wire logic  calib_done,
   input  test_cfg_t  cfg,
   input  app_rsp_t   app_rsp,
   output app_req_t   app_req,
   output check_beat_t check_beat,
   output logic       iter_done,
   output iter_t      iteration,
   output logic       lfsr_nonzero,
   output logic       active,
   output logic       writing,
   output logic       reading,
   output logic       run_start
);

   seq_state_e state;
   seq_state_e next_state;

   logic [2:0] active_pipe;   // Host level crosses in here.
   logic       active_r;

   ddr_addr_t app_addr;
   ddr_addr_t verify_addr;
   ddr_data_t lfsr;
   logic      verify_done;    // Beat for the stop address has returned.

   logic      reset_address;
   logic      incr_address;
   logic      incr_iteration;
   logic      load_lfsr;
   logic      write_done;     // End beat accepted.
   logic      rd_valid;

   always_ff @(posedge clk) begin
      if (reset) begin
         active_pipe <= '0;
         active      <= 1'b0;
         active_r    <= 1'b0;
      end else begin
         {active_r, active, active_pipe} <= {active, active_pipe, active_async};
      end
   end

   assign run_start = active & ~active_r;

   assign writing = (state == st_write0) || (state == st_write1) || (state == st_write2);
   assign reading = (state == st_read0) || (state == st_read1) || (state == st_read2) ||
                    (state == st_wait_reads_done);
   assign rd_valid = reading & app_rsp.rd_data_valid;

   always_comb begin
      next_state     = state;
      app_req.en     = 1'b0;
      app_req.wdf_wren = 1'b0;
      app_req.wdf_end  = 1'b0;
      reset_address  = 1'b0;
      incr_address   = 1'b0;
      incr_iteration = 1'b0;
      load_lfsr      = 1'b0;
      write_done     = 1'b0;
      case (state)
         st_idle: begin
            if (active && calib_done && app_rsp.rdy && app_rsp.wdf_rdy) begin
               reset_address = 1'b1;
               load_lfsr     = 1'b1;
               next_state    = st_write1;
            end
         end
         st_write0: begin
            if (!active)
               next_state = st_idle;                    // Between addresses.
            else if (app_rsp.rdy && app_rsp.wdf_rdy)
               next_state = st_write1;
         end
         st_write1: begin
            app_req.en       = 1'b1;                    // Command with first beat.
            app_req.wdf_wren = 1'b1;
            if (app_rsp.rdy && app_rsp.wdf_rdy)
               next_state = st_write2;
         end
         st_write2: begin
            app_req.wdf_wren = 1'b1;
            app_req.wdf_end  = 1'b1;
            if (app_rsp.wdf_rdy) begin
               write_done = 1'b1;
               if (!active) begin
                  next_state = st_idle;
               end else if (app_addr == cfg.stop) begin
                  reset_address = 1'b1;
                  next_state    = st_read0;
               end else begin
                  incr_address = 1'b1;
                  next_state   = app_rsp.rdy ? st_write1 : st_write0;
               end
            end
         end
         st_read0: begin
            if (app_rsp.rdy) begin
               load_lfsr  = 1'b1;                       // Same seed for verify.
               next_state = st_read1;
            end
         end
         st_read1: begin
            app_req.en = 1'b1;
            if (app_rsp.rdy)
               next_state = st_read2;
         end
         st_read2: begin
            if (!active) begin
               next_state = st_idle;
            end else if (app_rsp.rdy) begin
               if (app_addr == cfg.stop) begin
                  next_state = st_wait_reads_done;
               end else begin
                  incr_address = 1'b1;
                  next_state   = st_read1;
               end
            end
         end
         st_wait_reads_done: begin
            if (!active) begin
               next_state = st_idle;
            end else if (verify_done) begin
               reset_address  = 1'b1;
               incr_iteration = 1'b1;
               next_state     = st_load_lfsr;
            end
         end
         st_load_lfsr: begin
            load_lfsr  = 1'b1;
            next_state = st_write0;
         end
         default: next_state = st_idle;
      endcase
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         state       <= st_idle;
         app_addr    <= '0;
         verify_addr <= '0;
         verify_done <= 1'b0;
         iteration   <= '0;
         lfsr        <= '0;
      end else begin
         state <= next_state;
         if (reset_address) begin
            app_addr    <= '0;
            verify_addr <= '0;
            verify_done <= 1'b0;
         end else begin
            if (incr_address)
               app_addr <= app_addr + ddr_addr_t'(cfg.incr);
            if (rd_valid && app_rsp.rd_data_end) begin
               verify_addr <= verify_addr + ddr_addr_t'(cfg.incr);
               if (verify_addr == cfg.stop)
                  verify_done <= 1'b1;
            end
         end
         if (state == st_idle)
            iteration <= '0;
         else if (incr_iteration)
            iteration <= iteration + 1'b1;
         if (load_lfsr)
            lfsr <= {iteration, ~iteration};            // Seed from the iteration.
         else if (rd_valid || write_done)
            lfsr <= {lfsr[`DDR_DATA_W-2:0], lfsr[`DDR_LFSR_TAP_A] ^ lfsr[`DDR_LFSR_TAP_B] ^
                     lfsr[`DDR_LFSR_TAP_C] ^ lfsr[`DDR_LFSR_TAP_D]};
      end
   end

   assign app_req.addr     = app_addr;
   assign app_req.cmd      = writing ? cmd_write : cmd_read;
   assign app_req.wdf_data = lfsr ^ ddr_data_t'(app_addr);   // Same word on both beats.

   assign check_beat.valid    = rd_valid;
   assign check_beat.expected = lfsr ^ ddr_data_t'(verify_addr);
   assign check_beat.addr     = verify_addr;

   assign iter_done    = incr_iteration;
   assign lfsr_nonzero = |lfsr;

endmodule

`default_nettype wire

// ==== ddr_rwtest_checker.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "ddr_rwtest_params.svh"

module ddr_rwtest_checker import ddr_rwtest_pkg::*; (
   input  wire logic   clk,
   input  wire logic   reset,
   input  check_beat_t check_beat,
   input  ddr_data_t   rd_data,
   input  wire logic   iter_done,
   input  wire logic   lfsr_nonzero,
   input  wire logic   active,
   input  wire logic   writing,
   input  wire logic   clear_fail,
   input  iter_t       iteration,
   output test_status_t status
);

   logic      pass;
   logic      fail;
   logic      comp_error;     // Last compared beat was wrong.
   err_cnt_t  errors;
   ddr_addr_t error_addr;

   always_ff @(posedge clk) begin
      if (reset) begin
         pass <= 1'b0;
      end else if (!active || clear_fail) begin
         pass <= 1'b0;
      end else if (comp_error) begin
         pass <= 1'b0;
      end else if (iter_done && !fail && lfsr_nonzero) begin
         pass <= 1'b1;                                 // A whole iteration verified clean.
      end
   end

   always_ff @(posedge clk) begin
      if (reset || clear_fail) begin
         fail       <= 1'b0;
         comp_error <= 1'b0;
         errors     <= '0;
         error_addr <= '0;
      end else if (check_beat.valid) begin
         if (rd_data == check_beat.expected) begin
            comp_error <= 1'b0;
         end else begin
            fail       <= 1'b1;
            comp_error <= 1'b1;
            if (errors == '0)
               error_addr <= check_beat.addr;          // First failure only.
            if (errors < err_cnt_t'(`DDR_ERR_MAX))
               errors <= errors + 1'b1;
         end
      end else if (writing) begin
         comp_error <= 1'b0;
      end
   end

   assign status.pass       = pass;
   assign status.fail       = fail;
   assign status.iteration  = iteration;
   assign status.errors     = errors;
   assign status.error_addr = error_addr;

endmodule

`default_nettype wire

// ==== ddr_rwtest_stats.sv ====
`timescale 1ns/1ps
`default_nettype none

module ddr_rwtest_stats import ddr_rwtest_pkg::*; (
   input  wire logic  clk,
   input  wire logic  reset,
   input  wire logic  run_start,
   input  wire logic  writing,
   input  wire logic  reading,
   input  wire logic  rdy,
   input  wire logic  rd_data_valid,
   output perf_stats_t stats
);

   perf_cnt_t read_read;
   perf_cnt_t read_idle;
   perf_cnt_t write_write;
   perf_cnt_t write_idle;
   stall_t    read_stall;     // Current run of cycles without a beat.
   stall_t    write_stall;    // Current run of cycles without rdy.
   stall_t    max_read_stall;
   stall_t    max_write_stall;

   function automatic perf_cnt_t cnt_inc(input perf_cnt_t cnt);
      return (cnt == '1) ? cnt : cnt + 1'b1;
   endfunction

   function automatic stall_t stall_inc(input stall_t cnt);
      return (cnt == '1) ? cnt : cnt + 1'b1;
   endfunction

   always_ff @(posedge clk) begin
      if (reset || run_start) begin
         read_read       <= '0;
         read_idle       <= '0;
         read_stall      <= '0;
         max_read_stall  <= '0;
      end else if (reading) begin
         if (rd_data_valid) begin
            read_read  <= cnt_inc(read_read);
            read_stall <= '0;
            if (read_stall > max_read_stall)
               max_read_stall <= read_stall;            // Stall ended, keep the longest.
         end else begin
            read_idle  <= cnt_inc(read_idle);
            read_stall <= stall_inc(read_stall);
         end
      end
   end

   always_ff @(posedge clk) begin
      if (reset || run_start) begin
         write_write     <= '0;
         write_idle      <= '0;
         write_stall     <= '0;
         max_write_stall <= '0;
      end else if (writing) begin
         if (rdy) begin
            write_write <= cnt_inc(write_write);
            write_stall <= '0;
            if (write_stall > max_write_stall)
               max_write_stall <= write_stall;
         end else begin
            write_idle  <= cnt_inc(write_idle);
            write_stall <= stall_inc(write_stall);
         end
      end
   end

   assign stats.read_read       = read_read;
   assign stats.read_idle       = read_idle;
   assign stats.write_write     = write_write;
   assign stats.write_idle      = write_idle;
   assign stats.max_read_stall  = max_read_stall;
   assign stats.max_write_stall = max_write_stall;

endmodule

`default_nettype wire

// ==== ddr_rwtest_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module ddr_rwtest_top import ddr_rwtest_pkg::*; (
   input  wire logic    clk,
   input  wire logic    reset,
   input  wire logic    active,       // Asynchronous host level.
   input  wire logic    calib_done,
   input  wire logic    clear_fail,
   input  test_cfg_t    cfg,
   input  app_rsp_t     app_rsp,
   output app_req_t     app_req,
   output test_status_t status,
   output perf_stats_t  stats
);

   check_beat_t check_beat;
   iter_t       iteration;
   logic        iter_done;
   logic        lfsr_nonzero;
   logic        active_sync;
   logic        writing;
   logic        reading;
   logic        run_start;

   ddr_rwtest_sequencer ddr_rwtest_sequencer_i (
      .clk          (clk),
      .reset        (reset),
      .active_async (active),
      .calib_done   (calib_done),
      .cfg          (cfg),
      .app_rsp      (app_rsp),
      .app_req      (app_req),
      .check_beat   (check_beat),
      .iter_done    (iter_done),
      .iteration    (iteration),
      .lfsr_nonzero (lfsr_nonzero),
      .active       (active_sync),
      .writing      (writing),
      .reading      (reading),
      .run_start    (run_start)
   );

   ddr_rwtest_checker ddr_rwtest_checker_i (
      .clk          (clk),
      .reset        (reset),
      .check_beat   (check_beat),
      .rd_data      (app_rsp.rd_data),
      .iter_done    (iter_done),
      .lfsr_nonzero (lfsr_nonzero),
      .active       (active_sync),
      .writing      (writing),
      .clear_fail   (clear_fail),
      .iteration    (iteration),
      .status       (status)
   );

   ddr_rwtest_stats ddr_rwtest_stats_i (
      .clk           (clk),
      .reset         (reset),
      .run_start     (run_start),
      .writing       (writing),
      .reading       (reading),
      .rdy           (app_rsp.rdy),
      .rd_data_valid (app_rsp.rd_data_valid),
      .stats         (stats)
   );

endmodule

`default_nettype wire

// ==== tb_ddr_rwtest.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "ddr_rwtest_params.svh"

module tb_ddr_rwtest import ddr_rwtest_pkg::*; ();

   localparam int ITER_TIMEOUT  = 4000;   // Cycles allowed for one pass.
   localparam int DRAIN_TIMEOUT = 300;
   localparam int QUIET_CYCLES  = 12;

   typedef struct packed {
      ddr_addr_t   addr;
      logic [31:0] due;
   } read_slot_t;

   logic         clk;
   logic         reset;
   logic         active;
   logic         calib_done;
   logic         clear_fail;
   test_cfg_t    cfg;
   app_rsp_t     app_rsp;
   app_req_t     app_req;
   test_status_t status;
   perf_stats_t  stats;

   integer       seed = 83;
   int           cycle = 0;

   // Controller model state.
   ddr_data_t    mem [ddr_addr_t];
   read_slot_t   pending [$];          // Reads in flight, oldest first.
   read_slot_t   new_slot;
   read_slot_t   ret_slot;
   ddr_data_t    rword;
   logic         stall;
   logic         stall_mode;
   logic         corrupted;
   incr_t        case_incr;
   ddr_addr_t    case_stop;
   ddr_addr_t    case_corrupt;
   ddr_addr_t    next_waddr;
   ddr_addr_t    next_raddr;
   ddr_data_t    model_lfsr;
   iter_t        model_iter;           // Passes whose last beat was returned.
   int           delivered;
   int           gap;
   int           max_gap;
   logic         in_run;

   // Phase bookkeeping for the statistics.
   int           wr_busy;
   int           wr_idle;
   int           wstall;
   int           max_wstall;
   int           rd_cycles;
   logic         rphase;               // Read phase of the current pass.
   iter_t        seen_iter;

   int           fd;
   int           n_cases;
   string        line;
   incr_t        f_incr;
   ddr_addr_t    f_stop;
   ddr_addr_t    f_corrupt;
   logic         f_stall;

   ddr_rwtest_top ddr_rwtest_top_i (
      .clk        (clk),
      .reset      (reset),
      .active     (active),
      .calib_done (calib_done),
      .clear_fail (clear_fail),
      .cfg        (cfg),
      .app_rsp    (app_rsp),
      .app_req    (app_req),
      .status     (status),
      .stats      (stats)
   );

   initial begin
      clk = 1'b0;
      forever #2 clk = ~clk;
   end

   task automatic abort_run(input string msg);
      $display("%s", msg);
      $display("tests failed");
      $fatal(1, "simulation stopped at the first error");
   endtask

   task automatic fail_value(input string msg);
      abort_run($sformatf("[FAIL] t=%0t %s", $time, msg));
   endtask

   task automatic check_word(input ddr_data_t got, input ddr_data_t exp, input string what);
      if (got !== exp)
         fail_value($sformatf("%s is %h, expected %h", what, got, exp));
   endtask

   task automatic check_addr(input ddr_addr_t got, input ddr_addr_t exp, input string what);
      if (got !== exp)
         fail_value($sformatf("%s is %h, expected %h", what, got, exp));
   endtask

   task automatic check_flag(input logic got, input logic exp, input string what);
      if (got !== exp)
         fail_value($sformatf("%s is %b, expected %b", what, got, exp));
   endtask

   task automatic check_count(input perf_cnt_t got, input perf_cnt_t exp, input string what);
      if (got !== exp)
         fail_value($sformatf("%s is %0d, expected %0d", what, got, exp));
   endtask

   task automatic check_stall(input stall_t got, input stall_t lo, input stall_t hi,
                              input string what);
      if (got < lo || got > hi || $isunknown(got))
         fail_value($sformatf("%s is %0d, expected %0d to %0d", what, got, lo, hi));
   endtask

   task automatic check_status(input test_status_t got, input test_status_t exp,
                               input string what);
      string got_s;
      string exp_s;
      got_s = $sformatf("pass %b fail %b iter %0d errors %0d addr %h",
                        got.pass, got.fail, got.iteration, got.errors, got.error_addr);
      exp_s = $sformatf("pass %b fail %b iter %0d errors %0d addr %h",
                        exp.pass, exp.fail, exp.iteration, exp.errors, exp.error_addr);
      if (got !== exp)
         fail_value($sformatf("%s is %s, expected %s", what, got_s, exp_s));
   endtask

   function automatic test_status_t make_status(input logic p, input logic f, input iter_t it,
                                                input err_cnt_t e, input ddr_addr_t a);
      test_status_t s;
      s.pass       = p;
      s.fail       = f;
      s.iteration  = it;
      s.errors     = e;
      s.error_addr = a;
      return s;
   endfunction

   function automatic ddr_data_t lfsr_next(input ddr_data_t s);
      logic fb;
      fb = ^(s & 32'h8020_0003);             // Taps 31, 21, 1 and 0.
      return {s[`DDR_DATA_W-2:0], fb};
   endfunction

   function automatic ddr_addr_t next_address(input ddr_addr_t a);
      return (a == case_stop) ? '0 : a + ddr_addr_t'(case_incr);
   endfunction

   // Request side of the controller, sampled before the DUT flops update.
   always @(posedge clk) begin
      if (!reset && app_req.cmd == cmd_write) begin
         if (app_rsp.rdy) begin
            wr_busy++;
            if (wstall > max_wstall)
               max_wstall = wstall;
            wstall = 0;
         end else begin
            wr_idle++;
            wstall++;
         end
      end
      if (!reset && rphase)
         rd_cycles++;
      if (!reset && app_req.en && app_rsp.rdy) begin
         if (app_req.cmd == cmd_write) begin
            check_addr(app_req.addr, next_waddr, "write address");
            check_flag(app_req.wdf_wren, 1'b1, "wdf_wren with write command");
            check_flag(app_req.wdf_end, 1'b0, "wdf_end on first beat");
            if (app_req.addr == '0)
               model_lfsr = {model_iter, ~model_iter};      // New seed per pass.
            check_word(app_req.wdf_data, model_lfsr ^ ddr_data_t'(app_req.addr), "write data");
            mem[app_req.addr] = app_req.wdf_data;
            next_waddr = next_address(app_req.addr);
         end else begin
            check_addr(app_req.addr, next_raddr, "read address");
            if (!mem.exists(app_req.addr))
               abort_run("Read command for an address that was never written");
            new_slot.addr = app_req.addr;
            new_slot.due  = cycle + 3 + ($random(seed) & 3);
            if (pending.size() != 0 && new_slot.due <= pending[$].due)
               new_slot.due = pending[$].due + 1;         // Returns stay in order.
            pending.push_back(new_slot);
            next_raddr = next_address(app_req.addr);
         end
      end
      if (!reset && app_req.wdf_wren && app_rsp.wdf_rdy && app_req.wdf_end) begin
         check_word(app_req.wdf_data, mem[app_req.addr], "second write beat");
         model_lfsr = lfsr_next(model_lfsr);
         if (app_req.addr == case_stop)
            rphase = 1'b1;                               // Reads follow the last write.
      end
   end

   // Response side, driven on the falling edge.
   always @(negedge clk) begin
      cycle = cycle + 1;
      if (status.iteration != seen_iter) begin
         rphase    = 1'b0;                               // Pass finished on the last edge.
         seen_iter = status.iteration;
      end
      stall = 1'b0;
      if (stall_mode)
         stall = (($random(seed) & 3) == 0);
      app_rsp.rdy           = ~stall;
      app_rsp.wdf_rdy       = ~stall;
      app_rsp.rd_data_valid = 1'b0;
      app_rsp.rd_data_end   = 1'b0;
      if (pending.size() != 0 && pending[0].due <= cycle) begin
         ret_slot = pending.pop_front();
         rword    = mem[ret_slot.addr];
         if (ret_slot.addr == case_corrupt && !corrupted && case_corrupt != '1) begin
            rword[0]  = ~rword[0];
            corrupted = 1'b1;
         end
         app_rsp.rd_data       = rword;
         app_rsp.rd_data_valid = 1'b1;
         app_rsp.rd_data_end   = 1'b1;
         delivered = delivered + 1;
         if (in_run && gap > max_gap)
            max_gap = gap;
         gap    = 0;
         in_run = (ret_slot.addr != case_stop);
         if (ret_slot.addr == case_stop)
            model_iter = model_iter + 1'b1;
      end else if (in_run) begin
         gap = gap + 1;
      end
   end

   task automatic wait_iteration(input iter_t target);
      int n;
      n = 0;
      while (status.iteration != target) begin
         @(negedge clk);
         n++;
         if (n > ITER_TIMEOUT)
            abort_run($sformatf("Timeout waiting for pass %0d to complete", target));
      end
   endtask

   task automatic check_reset_state();
      check_flag(app_req.en, 1'b0, "en after reset");
      check_flag(app_req.wdf_wren, 1'b0, "wdf_wren after reset");
      check_flag(app_req.wdf_end, 1'b0, "wdf_end after reset");
      check_status(status, make_status(1'b0, 1'b0, '0, '0, '0), "status after reset");
      check_count(stats.read_read, '0, "read_read after reset");
      check_count(stats.read_idle, '0, "read_idle after reset");
      check_count(stats.write_write, '0, "write_write after reset");
      check_count(stats.write_idle, '0, "write_idle after reset");
      check_stall(stats.max_read_stall, '0, '0, "max_read_stall after reset");
      check_stall(stats.max_write_stall, '0, '0, "max_write_stall after reset");
   endtask

   task automatic check_read_stats(input string what);
      check_count(stats.read_read, perf_cnt_t'(delivered), {what, " read beats"});
      check_count(stats.read_idle, perf_cnt_t'(rd_cycles - delivered), {what, " read idle"});
      check_stall(stats.max_read_stall, stall_t'(max_gap), '1, {what, " longest read stall"});
   endtask

   task automatic check_write_stats(input string what);
      check_count(stats.write_write, perf_cnt_t'(wr_busy), {what, " write busy"});
      check_count(stats.write_idle, perf_cnt_t'(wr_idle), {what, " write idle"});
      check_stall(stats.max_write_stall, stall_t'(max_wstall), stall_t'(max_wstall),
                  {what, " longest write stall"});
   endtask

   task automatic stop_run();
      int n;
      int low_run;
      n       = 0;
      low_run = 0;
      active  = 1'b0;
      while (low_run < QUIET_CYCLES) begin
         @(negedge clk);
         n++;
         if (app_req.en || app_req.wdf_wren)
            low_run = 0;
         else
            low_run++;
         if (n > DRAIN_TIMEOUT)
            abort_run("Timeout waiting for en and wdf_wren to stay low after active dropped");
      end
      check_status(status, make_status(1'b0, 1'b0, '0, '0, '0), "status while inactive");
      n = 0;
      @(posedge clk);
      while (pending.size() != 0) begin
         @(posedge clk);
         n++;
         if (n > DRAIN_TIMEOUT)
            abort_run("Timeout waiting for outstanding reads to return");
      end
   endtask

   task automatic run_case(input incr_t incr, input ddr_addr_t stop, input ddr_addr_t corrupt,
                           input logic stall_on);
      logic corrupting;
      corrupting = (corrupt != '1);
      @(posedge clk);                                    // Model is quiet here.
      mem.delete();
      pending.delete();
      next_waddr   = '0;
      next_raddr   = '0;
      model_iter   = '0;
      delivered    = 0;
      gap          = 0;
      max_gap      = 0;
      in_run       = 1'b0;
      corrupted    = 1'b0;
      wr_busy      = 0;
      wr_idle      = 0;
      wstall       = 0;
      max_wstall   = 0;
      rd_cycles    = 0;
      rphase       = 1'b0;
      case_incr    = incr;
      case_stop    = stop;
      case_corrupt = corrupt;
      stall_mode   = stall_on;
      @(negedge clk);
      cfg.incr = incr;
      cfg.stop = stop;
      active   = 1'b1;
      wait_iteration(1);
      if (corrupting)
         check_status(status, make_status(1'b0, 1'b1, 1, 1, corrupt), "status after bad pass");
      else
         check_status(status, make_status(1'b1, 1'b0, 1, '0, '0), "status after clean pass");
      check_read_stats("first pass");
      check_write_stats("first pass");
      if (corrupting) begin
         clear_fail = 1'b1;
         @(negedge clk);
         clear_fail = 1'b0;
         check_status(status, make_status(1'b0, 1'b0, 1, '0, '0), "status after clear_fail");
      end
      wait_iteration(2);
      check_status(status, make_status(1'b1, 1'b0, 2, '0, '0), "status after second pass");
      check_read_stats("second pass");
      check_write_stats("second pass");
      stop_run();
   endtask

   initial begin
      reset        = 1'b1;
      active       = 1'b0;
      calib_done   = 1'b0;
      clear_fail   = 1'b0;
      cfg          = '0;
      app_rsp      = '0;
      stall_mode   = 1'b0;
      corrupted    = 1'b0;
      in_run       = 1'b0;
      gap          = 0;
      max_gap      = 0;
      delivered    = 0;
      wr_busy      = 0;
      wr_idle      = 0;
      wstall       = 0;
      max_wstall   = 0;
      rd_cycles    = 0;
      rphase       = 1'b0;
      seen_iter    = '0;
      case_incr    = 8'd1;
      case_stop    = '0;
      case_corrupt = '1;
      n_cases      = 0;
      repeat (8) @(negedge clk);
      reset      = 1'b0;
      calib_done = 1'b1;
      @(negedge clk);
      check_reset_state();
      fd = $fopen("ddr_rwtest_stim.txt", "r");
      if (fd == 0)
         abort_run("Cannot open the stimulus file ddr_rwtest_stim.txt");
      while (!$feof(fd)) begin
         if ($fgets(line, fd) == 0)
            continue;
         if (line.len() < 2 || line[0] == "#")
            continue;                                    // Column notes and blank lines.
         if ($sscanf(line, "%h %h %h %h", f_incr, f_stop, f_corrupt, f_stall) != 4)
            abort_run({"Malformed stimulus line: ", line});
         run_case(f_incr, f_stop, f_corrupt, f_stall);
         n_cases++;
      end
      $fclose(fd);
      if (n_cases == 0)
         abort_run("The stimulus file holds no test cases");
      $display("all tests passed");
      $finish;
   end

endmodule

`default_nettype wire

// ==== ddr_rwtest_stim.txt ====
# incr stop_addr corrupt_addr stall_mode, all in hex
# corrupt_addr 3fffffff means the model never corrupts a read
01 0000000f 3fffffff 0
02 00000020 00000010 0
04 00000040 3fffffff 1
01 0000001f 00000007 1
10 00000100 00000000 0
08 00000080 00000080 1
03 0000002d 3fffffff 1
ff 000003fc 000002fd 1
01 00000000 3fffffff 0
05 00000032 00000019 1

// ==== ddr_rwtest.f ====
+incdir+.
ddr_rwtest_pkg.sv
ddr_rwtest_sequencer.sv
ddr_rwtest_checker.sv
ddr_rwtest_stats.sv
ddr_rwtest_top.sv
tb_ddr_rwtest.sv

// ==== Bender.yml ====
package:
  name: ddr_rwtest

export_include_dirs:
  - .

sources:
  - include_dirs:
      - .
    files:
      - ddr_rwtest_pkg.sv
      - ddr_rwtest_sequencer.sv
      - ddr_rwtest_checker.sv
      - ddr_rwtest_stats.sv
      - ddr_rwtest_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_ddr_rwtest.sv
